// File: source/mem_types_pkg.sv
package mem_types_pkg;

  // ------------------------------
  // data path widths
  // ------------------------------

  // one data word
  typedef logic [31:0] word_t;

  // byte address
  typedef logic [31:0] addr_t;

  // register file index
  typedef logic [4:0] reg_addr_t;

  // one bit per byte lane
  typedef logic [3:0] strb_t;

  // ------------------------------
  // memory sizing
  // ------------------------------

  // 1 K words of data RAM
  localparam int RAM_ADDR_BITS = 10;

  // word index into the RAM
  typedef logic [RAM_ADDR_BITS-1:0] ram_addr_t;

  // store buffer entries, must stay a power of two
  localparam int SB_DEPTH = 4;
  localparam int SB_PTR_BITS = 2;

endpackage

// File: source/mem_op_pkg.sv
package mem_op_pkg;

  // ------------------------------
  // memory operations
  // ------------------------------

  // ten operations do not fit in three bits
  typedef enum logic [3:0] {
    op_none  = 4'd0,
    op_lb    = 4'd1,
    op_lbu   = 4'd2,
    op_lh    = 4'd3,
    op_lhu   = 4'd4,
    op_lw    = 4'd5,
    op_sb    = 4'd6,
    op_sh    = 4'd7,
    op_sw    = 4'd8,
    op_fence = 4'd9
  } mem_op_t;

  function automatic logic is_load(mem_op_t op);
    return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
  endfunction

  function automatic logic is_store(mem_op_t op);
    return op inside {op_sb, op_sh, op_sw};
  endfunction

  // anything that talks to the store buffer
  function automatic logic is_mem(mem_op_t op);
    return is_load(op) || is_store(op) || (op == op_fence);
  endfunction

  // ------------------------------
  // store buffer FSM
  // ------------------------------

  typedef enum logic [1:0] {
    sb_idle,
    sb_drain,
    sb_read,
    sb_reply
  } sb_state_t;

endpackage

// File: source/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit
  import mem_types_pkg::*;
  import mem_op_pkg::*;
(
  input  mem_op_t op,
  input  addr_t   addr,
  input  word_t   sdata,
  input  word_t   rdata,
  output word_t   wdata,
  output strb_t   wstrb,
  output word_t   result
);

  word_t lane;

  // store side, replicate across lanes
  always_comb begin
    case (op)
      op_sb: begin
        wdata = {4{sdata[7:0]}};
        wstrb = strb_t'(4'b0001 << addr[1:0]);
      end
      op_sh: begin
        wdata = {2{sdata[15:0]}};
        wstrb = addr[1] ? 4'b1100 : 4'b0011;
      end
      op_sw: begin
        wdata = sdata;
        wstrb = 4'b1111;
      end
      default: begin
        wdata = sdata;
        wstrb = 4'b0000;
      end
    endcase
  end

  // addressed lane moved down to bit 0
  assign lane = rdata >> {addr[1:0], 3'b000};

  // load side extension
  always_comb begin
    case (op)
      op_lb:   result = {{24{lane[7]}}, lane[7:0]};
      op_lbu:  result = {24'h000000, lane[7:0]};
      op_lh:   result = {{16{lane[15]}}, lane[15:0]};
      op_lhu:  result = {16'h0000, lane[15:0]};
      default: result = rdata;
    endcase
  end

endmodule

// File: source/store_buffer.sv
`timescale 1ns/1ps

module store_buffer
  import mem_types_pkg::*;
  import mem_op_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      mem_valid,
  input  mem_op_t   mem_op,
  input  addr_t     mem_addr,
  input  word_t     mem_wdata,
  input  strb_t     mem_wstrb,
  output logic      mem_ready,
  output word_t     mem_rdata,
  output logic      ram_we,
  output ram_addr_t ram_addr,
  output word_t     ram_wdata,
  output strb_t     ram_wstrb,
  input  word_t     ram_rdata
);

  // queue storage
  ram_addr_t q_addr [SB_DEPTH];
  word_t     q_data [SB_DEPTH];
  strb_t     q_strb [SB_DEPTH];

  logic [SB_PTR_BITS-1:0] wr_ptr;
  logic [SB_PTR_BITS-1:0] rd_ptr;
  logic [SB_PTR_BITS:0]   count;

  sb_state_t state;
  sb_state_t state_next;

  ram_addr_t req_word;
  ram_addr_t rd_addr;
  logic      full;
  logic      empty;
  logic      push;
  logic      drain;
  logic      load_ready;
  logic      fence_ready;

  assign req_word = mem_addr[RAM_ADDR_BITS+1:2];
  assign full     = (count == (SB_PTR_BITS+1)'(SB_DEPTH));
  assign empty    = (count == '0);

  // stores go in without delay unless full
  assign push = mem_valid && is_store(mem_op) && !full;

  // ------------------------------
  // state selection
  // ------------------------------

  always_comb begin
    drain      = 1'b0;
    state_next = state;
    case (state)
      sb_idle, sb_drain: begin
        if (!empty) begin
          drain      = 1'b1;
          state_next = sb_drain;
        end else if (mem_valid && is_load(mem_op)) begin
          state_next = sb_read;
        end else begin
          state_next = sb_idle;
        end
      end
      sb_read:  state_next = sb_reply;
      sb_reply: state_next = sb_idle;
      default:  state_next = sb_idle;
    endcase
  end

  // read data only belongs to the load that started it
  assign load_ready = (state == sb_reply) && mem_valid && is_load(mem_op) &&
                      empty && (req_word == rd_addr);
  assign fence_ready = mem_valid && (mem_op == op_fence) && empty;

  assign mem_ready = push || load_ready || fence_ready;
  assign mem_rdata = ram_rdata;

  // RAM port follows the head entry unless a read is in flight
  assign ram_we    = drain;
  assign ram_addr  = (state == sb_read) ? rd_addr : q_addr[rd_ptr];
  assign ram_wdata = q_data[rd_ptr];
  assign ram_wstrb = q_strb[rd_ptr];

  // ------------------------------
  // registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (!rst) begin
      state  <= sb_idle;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      state <= state_next;
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (drain) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, drain})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_addr[wr_ptr] <= req_word;
      q_data[wr_ptr] <= mem_wdata;
      q_strb[wr_ptr] <= mem_wstrb;
    end
    if (state_next == sb_read) begin
      rd_addr <= req_word;
    end
  end

endmodule

// File: source/data_ram.sv
`timescale 1ns/1ps

module data_ram
  import mem_types_pkg::*;
(
  input  logic      clk,
  input  logic      we,
  input  ram_addr_t addr,
  input  word_t     wdata,
  input  strb_t     wstrb,
  output word_t     rdata
);

  word_t mem [2**RAM_ADDR_BITS];

  // byte lanes written separately
  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < 4; i++) begin
        if (wstrb[i]) begin
          mem[addr][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  // registered read, old data on a collision
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

// File: source/memory_stage.sv
`timescale 1ns/1ps

module memory_stage
  import mem_types_pkg::*;
  import mem_op_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      ex_valid,
  input  mem_op_t   ex_op,
  input  addr_t     ex_addr,
  input  word_t     ex_sdata,
  input  logic      ex_wren,
  input  reg_addr_t ex_waddr,
  input  word_t     ex_wdata,
  input  logic      flush,
  output logic      stall,
  output mem_op_t   lsu_op,
  output addr_t     lsu_addr,
  output word_t     lsu_sdata,
  output word_t     lsu_rdata,
  input  word_t     st_wdata,
  input  strb_t     st_wstrb,
  input  word_t     load_result,
  output logic      mem_valid,
  output mem_op_t   mem_op,
  output addr_t     mem_addr,
  output word_t     mem_wdata,
  output strb_t     mem_wstrb,
  input  logic      mem_ready,
  input  word_t     mem_rdata,
  output logic      rf_wren,
  output reg_addr_t rf_waddr,
  output word_t     rf_wdata
);

  // ------------------------------
  // stage register
  // ------------------------------

  logic      r_valid;
  mem_op_t   r_op;
  logic      r_wren;
  addr_t     r_addr;
  word_t     r_sdata;
  reg_addr_t r_waddr;
  word_t     r_wdata;

  logic r_load;
  logic write_ok;

  always_ff @(posedge clk) begin
    if (!rst) begin
      r_valid <= 1'b0;
      r_op    <= op_none;
      r_wren  <= 1'b0;
    end else if (flush) begin
      r_valid <= 1'b0;
      r_wren  <= 1'b0;
    end else if (!stall) begin
      r_valid <= ex_valid;
      r_op    <= ex_op;
      r_wren  <= ex_wren;
    end
  end

  // payload follows the control bits
  always_ff @(posedge clk) begin
    if (!stall) begin
      r_addr  <= ex_addr;
      r_sdata <= ex_sdata;
      r_waddr <= ex_waddr;
      r_wdata <= ex_wdata;
    end
  end

  assign r_load = is_load(r_op);

  // ------------------------------
  // request and LSU
  // ------------------------------

  assign lsu_op    = r_op;
  assign lsu_addr  = r_addr;
  assign lsu_sdata = r_sdata;
  assign lsu_rdata = mem_rdata;

  assign mem_valid = r_valid && is_mem(r_op);
  assign mem_op    = r_op;
  assign mem_addr  = r_addr;
  assign mem_wdata = st_wdata;
  assign mem_wstrb = st_wstrb;

  // hold until the handshake, flush lets go
  assign stall = mem_valid && !mem_ready && !flush;

  // ------------------------------
  // write-back
  // ------------------------------

  // loads write on the handshake edge only
  assign write_ok = (r_op == op_none) || (r_load && mem_ready);

  assign rf_wren  = r_valid && r_wren && write_ok && (r_waddr != '0) && !flush;
  assign rf_waddr = r_waddr;
  assign rf_wdata = r_load ? load_result : r_wdata;

endmodule

// File: source/memory_top.sv
`timescale 1ns/1ps

module memory_top
  import mem_types_pkg::*;
  import mem_op_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      ex_valid,
  input  mem_op_t   ex_op,
  input  addr_t     ex_addr,
  input  word_t     ex_sdata,
  input  logic      ex_wren,
  input  reg_addr_t ex_waddr,
  input  word_t     ex_wdata,
  input  logic      flush,
  output logic      stall,
  output logic      rf_wren,
  output reg_addr_t rf_waddr,
  output word_t     rf_wdata
);

  // stage to LSU
  mem_op_t lsu_op;
  addr_t   lsu_addr;
  word_t   lsu_sdata;
  word_t   lsu_rdata;
  word_t   st_wdata;
  strb_t   st_wstrb;
  word_t   load_result;

  // stage to store buffer
  logic    mem_valid;
  logic    mem_ready;
  mem_op_t mem_op;
  addr_t   mem_addr;
  word_t   mem_wdata;
  strb_t   mem_wstrb;
  word_t   mem_rdata;

  // store buffer to RAM
  logic      ram_we;
  ram_addr_t ram_addr;
  word_t     ram_wdata;
  strb_t     ram_wstrb;
  word_t     ram_rdata;

  memory_stage i_memory_stage (
    .clk         (clk),
    .rst         (rst),
    .ex_valid    (ex_valid),
    .ex_op       (ex_op),
    .ex_addr     (ex_addr),
    .ex_sdata    (ex_sdata),
    .ex_wren     (ex_wren),
    .ex_waddr    (ex_waddr),
    .ex_wdata    (ex_wdata),
    .flush       (flush),
    .stall       (stall),
    .lsu_op      (lsu_op),
    .lsu_addr    (lsu_addr),
    .lsu_sdata   (lsu_sdata),
    .lsu_rdata   (lsu_rdata),
    .st_wdata    (st_wdata),
    .st_wstrb    (st_wstrb),
    .load_result (load_result),
    .mem_valid   (mem_valid),
    .mem_op      (mem_op),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata),
    .rf_wren     (rf_wren),
    .rf_waddr    (rf_waddr),
    .rf_wdata    (rf_wdata)
  );

  load_store_unit i_load_store_unit (
    .op     (lsu_op),
    .addr   (lsu_addr),
    .sdata  (lsu_sdata),
    .rdata  (lsu_rdata),
    .wdata  (st_wdata),
    .wstrb  (st_wstrb),
    .result (load_result)
  );

  store_buffer i_store_buffer (
    .clk       (clk),
    .rst       (rst),
    .mem_valid (mem_valid),
    .mem_op    (mem_op),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_wstrb (ram_wstrb),
    .ram_rdata (ram_rdata)
  );

  data_ram i_data_ram (
    .clk   (clk),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .wstrb (ram_wstrb),
    .rdata (ram_rdata)
  );

endmodule

// File: testbench/memory_stage_chk.sv
`timescale 1ns/1ps

module memory_stage_chk
  import mem_types_pkg::*;
  import mem_op_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      flush,
  input logic      stall,
  input logic      mem_valid,
  input logic      mem_ready,
  input mem_op_t   mem_op,
  input addr_t     mem_addr,
  input word_t     mem_wdata,
  input strb_t     mem_wstrb,
  input logic      rf_wren,
  input reg_addr_t rf_waddr
);

  int fail_count = 0;

  // request held until the buffer takes it
  request_stable: assert property (@(posedge clk) disable iff (!rst)
    mem_valid && !mem_ready && !flush |=>
      mem_valid && $stable(mem_op) && $stable(mem_addr) &&
      $stable(mem_wdata) && $stable(mem_wstrb))
    else begin
      fail_count++;
      $error("memory request changed before it was accepted");
    end

  no_x0_write: assert property (@(posedge clk) disable iff (!rst)
    !(rf_wren && rf_waddr == '0))
    else begin
      fail_count++;
      $error("register write to x0");
    end

  quiet_after_reset: assert property (@(posedge clk)
    !rst |=> !stall && !rf_wren)
    else begin
      fail_count++;
      $error("stall or rf_wren high right after reset");
    end

endmodule

// File: testbench/memory_scoreboard.sv
`timescale 1ns/1ps

module memory_scoreboard
  import mem_types_pkg::*;
  import mem_op_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      ex_valid,
  input  mem_op_t   ex_op,
  input  addr_t     ex_addr,
  input  word_t     ex_sdata,
  input  logic      ex_wren,
  input  reg_addr_t ex_waddr,
  input  word_t     ex_wdata,
  input  logic      flush,
  input  logic      stall,
  input  logic      rf_wren,
  input  reg_addr_t rf_waddr,
  input  word_t     rf_wdata,
  input  logic      test_end,
  input  int        test_num,
  input  logic      final_report,
  output logic      idle,
  output int        errors
);

  // byte image of the data RAM with the same 4 KB aliasing
  logic [7:0] ref_mem [4096];
  reg_addr_t  exp_addr [$];
  word_t      exp_data [$];

  int checks = 0;
  int error_count = 0;
  int test_checks = 0;
  int test_errors = 0;
  int tests = 0;
  int flushes = 0;

  logic stall_known = 1'b0;
  logic stall_exp   = 1'b0;
  logic after_flush = 1'b0;

  assign errors = error_count;

  function automatic string test_name(int num);
    case (num)
      1: return "plain results";
      2: return "widths and alignment";
      3: return "store burst";
      4: return "load after store";
      5: return "fences";
      6: return "flush";
      default: return "unknown";
    endcase
  endfunction

  // ------------------------------
  // reference model
  // ------------------------------

  function automatic word_t expected_load(mem_op_t op, addr_t addr);
    logic [7:0] b [4];
    for (int i = 0; i < 4; i++) begin
      b[i] = ref_mem[addr[11:0] + 12'(i)];
    end
    case (op)
      op_lb:   return {{24{b[0][7]}}, b[0]};
      op_lbu:  return {24'h000000, b[0]};
      op_lh:   return {{16{b[1][7]}}, b[1], b[0]};
      op_lhu:  return {16'h0000, b[1], b[0]};
      default: return {b[3], b[2], b[1], b[0]};
    endcase
  endfunction

  function automatic void apply_store(mem_op_t op, addr_t addr, word_t data);
    int n;
    case (op)
      op_sb:   n = 1;
      op_sh:   n = 2;
      default: n = 4;
    endcase
    for (int i = 0; i < n; i++) begin
      ref_mem[addr[11:0] + 12'(i)] = data[8*i +: 8];
    end
  endfunction

  function automatic void note_error();
    error_count++;
    test_errors++;
  endfunction

  // instruction enters the stage at the coming edge
  function automatic void accept();
    logic load;
    load = ex_op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
    // a load still waits for its read right after it enters
    stall_known = (ex_op == op_none) || (load && !after_flush);
    stall_exp   = load;
    after_flush = 1'b0;
    if (exp_addr.size() != 0) begin
      $display("time %0t: expected write to x%0d never happened", $time, exp_addr[0]);
      note_error();
      exp_addr.delete();
      exp_data.delete();
    end
    if (ex_op inside {op_sb, op_sh, op_sw}) begin
      apply_store(ex_op, ex_addr, ex_sdata);
    end
    if (ex_wren && ex_waddr != '0 && (ex_op == op_none || load)) begin
      exp_addr.push_back(ex_waddr);
      exp_data.push_back(load ? expected_load(ex_op, ex_addr) : ex_wdata);
    end
  endfunction

  // ------------------------------
  // compare at the falling edge
  // ------------------------------

  always @(negedge clk) begin
    reg_addr_t ea;
    word_t     ed;
    if (!rst) begin
      idle <= 1'b0;
    end else begin
      if (rf_wren) begin
        if (exp_addr.size() == 0) begin
          $display("time %0t: unexpected write to x%0d", $time, rf_waddr);
          note_error();
        end else begin
          ea = exp_addr.pop_front();
          ed = exp_data.pop_front();
          checks++;
          test_checks++;
          if (rf_waddr !== ea || rf_wdata !== ed) begin
            $display("Mismatch at time %0t: x%0d = %h, expected x%0d = %h",
                     $time, rf_waddr, rf_wdata, ea, ed);
            note_error();
          end
        end
      end
      if (stall_known) begin
        checks++;
        test_checks++;
        if (stall !== (stall_exp && !flush)) begin
          $display("Mismatch at time %0t: stall = %b, expected %b",
                   $time, stall, stall_exp && !flush);
          note_error();
        end
        stall_known = 1'b0;
      end
      if (flush) begin
        flushes++;
        after_flush = 1'b1;
        exp_addr.delete();
        exp_data.delete();
      end
      if (ex_valid && !stall && !flush) begin
        accept();
      end
      idle <= !stall && !ex_valid;
      if (test_end) begin
        if (exp_addr.size() != 0) begin
          $display("time %0t: write to x%0d missing at end of test", $time, exp_addr[0]);
          note_error();
          exp_addr.delete();
          exp_data.delete();
        end
        tests++;
        $display("test %0d (%s): %0d checks, %0d errors",
                 test_num, test_name(test_num), test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
      end
      if (final_report) begin
        $display("%0d tests, %0d checks, %0d errors, %0d flushes",
                 tests, checks, error_count, flushes);
      end
    end
  end

endmodule

// File: testbench/memory_tb.sv
`timescale 1ns/1ps

module memory_tb
  import mem_types_pkg::*;
  import mem_op_pkg::*;
();

  localparam int REGION_WORDS = 64;
  localparam int N_PLAIN      = 24;
  localparam int N_ALIGN      = 4 * 16;
  localparam int N_BURST_ST   = 12;
  localparam int N_BURST_LD   = 24;
  localparam int N_RAW        = 8;
  localparam int N_FENCE      = 60;
  localparam int N_FLUSH      = 40;
  localparam int TOTAL_INSTR  = N_PLAIN + REGION_WORDS + N_ALIGN + N_BURST_ST +
                                N_BURST_LD + 2 * N_RAW + N_FENCE + N_FLUSH;
  localparam int CYCLE_LIMIT  = 20 * TOTAL_INSTR + 200;

  logic      clk;
  logic      rst;
  logic      ex_valid;
  mem_op_t   ex_op;
  addr_t     ex_addr;
  word_t     ex_sdata;
  logic      ex_wren;
  reg_addr_t ex_waddr;
  word_t     ex_wdata;
  logic      flush;
  logic      stall;
  logic      rf_wren;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  logic test_end;
  int   test_num;
  logic final_report;
  logic idle;
  int   errors;
  int   cycles = 0;

  memory_top i_memory_top (
    .clk      (clk),
    .rst      (rst),
    .ex_valid (ex_valid),
    .ex_op    (ex_op),
    .ex_addr  (ex_addr),
    .ex_sdata (ex_sdata),
    .ex_wren  (ex_wren),
    .ex_waddr (ex_waddr),
    .ex_wdata (ex_wdata),
    .flush    (flush),
    .stall    (stall),
    .rf_wren  (rf_wren),
    .rf_waddr (rf_waddr),
    .rf_wdata (rf_wdata)
  );

  memory_scoreboard i_memory_scoreboard (
    .clk          (clk),
    .rst          (rst),
    .ex_valid     (ex_valid),
    .ex_op        (ex_op),
    .ex_addr      (ex_addr),
    .ex_sdata     (ex_sdata),
    .ex_wren      (ex_wren),
    .ex_waddr     (ex_waddr),
    .ex_wdata     (ex_wdata),
    .flush        (flush),
    .stall        (stall),
    .rf_wren      (rf_wren),
    .rf_waddr     (rf_waddr),
    .rf_wdata     (rf_wdata),
    .test_end     (test_end),
    .test_num     (test_num),
    .final_report (final_report),
    .idle         (idle),
    .errors       (errors)
  );

  bind memory_stage memory_stage_chk i_memory_stage_chk (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .stall     (stall),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_op    (mem_op),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .rf_wren   (rf_wren),
    .rf_waddr  (rf_waddr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------

  function automatic word_t fill_word(addr_t a);
    return (a * 32'h9e3779b1) ^ 32'h5a3c96e1;
  endfunction

  function automatic reg_addr_t pick_rd();
    return reg_addr_t'($urandom_range(31, 1));
  endfunction

  function automatic mem_op_t pick_load();
    case ($urandom_range(4))
      0:       return op_lb;
      1:       return op_lbu;
      2:       return op_lh;
      3:       return op_lhu;
      default: return op_lw;
    endcase
  endfunction

  function automatic mem_op_t pick_store();
    case ($urandom_range(2))
      0:       return op_sb;
      1:       return op_sh;
      default: return op_sw;
    endcase
  endfunction

  function automatic mem_op_t pick_op(bit with_fence);
    case ($urandom_range(with_fence ? 5 : 4))
      0:       return op_none;
      1, 2:    return pick_load();
      3, 4:    return pick_store();
      default: return op_fence;
    endcase
  endfunction

  // naturally aligned address inside the prefilled region
  function automatic addr_t pick_addr(mem_op_t op);
    int unsigned word;
    int unsigned off;
    word = $urandom_range(REGION_WORDS - 1);
    case (op)
      op_lb, op_lbu, op_sb: off = $urandom_range(3);
      op_lh, op_lhu, op_sh: off = 2 * $urandom_range(1);
      default:              off = 0;
    endcase
    return addr_t'(4 * word + off);
  endfunction

  // returns right after the edge that took the instruction
  task automatic send(mem_op_t op, addr_t addr, word_t sdata, logic wren,
                      reg_addr_t waddr, word_t wdata);
    logic taken;
    ex_valid <= 1'b1;
    ex_op    <= op;
    ex_addr  <= addr;
    ex_sdata <= sdata;
    ex_wren  <= wren;
    ex_waddr <= waddr;
    ex_wdata <= wdata;
    do begin
      @(negedge clk);
      taken = !stall;
      @(posedge clk);
    end while (!taken);
  endtask

  task automatic flush_last();
    flush    <= 1'b1;
    ex_valid <= 1'b0;
    @(posedge clk);
    flush <= 1'b0;
  endtask

  task automatic send_random(mem_op_t op, bit may_flush);
    logic kill;
    kill = may_flush && (op inside {op_none, op_lb, op_lbu, op_lh, op_lhu, op_lw}) &&
           ($urandom_range(3) == 0);
    send(op, pick_addr(op), $urandom, $urandom_range(7) != 0,
         reg_addr_t'($urandom_range(31)), $urandom);
    if (kill) begin
      flush_last();
    end
  endtask

  task automatic finish_test(int num);
    ex_valid <= 1'b0;
    do begin
      @(posedge clk);
    end while (!idle);
    test_num <= num;
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    mem_op_t op;
    addr_t   a;
    addr_t   la;
    addr_t   base;
    void'($urandom(32'h533589c0));
    rst          = 1'b0;
    ex_valid     = 1'b0;
    ex_op        = op_none;
    ex_addr      = '0;
    ex_sdata     = '0;
    ex_wren      = 1'b0;
    ex_waddr     = '0;
    ex_wdata     = '0;
    flush        = 1'b0;
    test_end     = 1'b0;
    test_num     = 0;
    final_report = 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);

    for (int i = 0; i < N_PLAIN; i++) begin
      send(op_none, addr_t'($urandom), '0, (i % 5) != 4,
           (i % 6 == 0) ? 5'd0 : pick_rd(), $urandom);
    end
    finish_test(1);

    // prefill so later loads never see undefined RAM
    for (int w = 0; w < REGION_WORDS; w++) begin
      send(op_sw, addr_t'(4 * w), fill_word(addr_t'(4 * w)), 1'b0, '0, '0);
    end
    for (int w = 0; w < 4; w++) begin
      base = addr_t'(4 * $urandom_range(REGION_WORDS - 1));
      send(op_sw, base, $urandom, 1'b0, '0, '0);
      send(op_sh, base + 2, $urandom, 1'b0, '0, '0);
      send(op_sb, base + 1, $urandom, 1'b0, '0, '0);
      for (int b = 0; b < 4; b++) begin
        send(op_lb, base + b, '0, 1'b1, pick_rd(), '0);
        send(op_lbu, base + b, '0, 1'b1, pick_rd(), '0);
      end
      for (int h = 0; h < 4; h += 2) begin
        send(op_lh, base + h, '0, 1'b1, pick_rd(), '0);
        send(op_lhu, base + h, '0, 1'b1, pick_rd(), '0);
      end
      send(op_lw, base, '0, 1'b1, pick_rd(), '0);
    end
    finish_test(2);

    for (int i = 0; i < N_BURST_ST; i++) begin
      send_random(pick_store(), 1'b0);
    end
    for (int i = 0; i < N_BURST_LD; i++) begin
      send_random(pick_load(), 1'b0);
    end
    finish_test(3);

    for (int i = 0; i < N_RAW; i++) begin
      op = pick_store();
      a  = pick_addr(op);
      send(op, a, $urandom, 1'b0, '0, '0);
      op = pick_load();
      la = pick_addr(op);
      send(op, {a[31:2], la[1:0]}, '0, 1'b1, pick_rd(), '0);
    end
    finish_test(4);

    for (int i = 0; i < N_FENCE; i++) begin
      send_random(pick_op(1'b1), 1'b0);
    end
    finish_test(5);

    for (int i = 0; i < N_FLUSH; i++) begin
      send_random(pick_op(1'b0), 1'b1);
    end
    finish_test(6);

    final_report <= 1'b1;
    @(posedge clk);
    final_report <= 1'b0;
    @(posedge clk);
    if (errors == 0 && i_memory_top.i_memory_stage.i_memory_stage_chk.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
source/mem_types_pkg.sv
source/mem_op_pkg.sv
source/load_store_unit.sv
source/store_buffer.sv
source/data_ram.sv
source/memory_stage.sv
source/memory_top.sv
testbench/memory_stage_chk.sv
testbench/memory_scoreboard.sv
testbench/memory_tb.sv

// File: Bender.yml
package:
  name: rv_memory_stage

sources:
  - files:
      - source/mem_types_pkg.sv
      - source/mem_op_pkg.sv
      - source/load_store_unit.sv
      - source/store_buffer.sv
      - source/data_ram.sv
      - source/memory_stage.sv
      - source/memory_top.sv
  - target: test
    files:
      - testbench/memory_stage_chk.sv
      - testbench/memory_scoreboard.sv
      - testbench/memory_tb.sv
